// ==== sba_pkg.sv ====
// Shared DMI and system bus types; 32-bit addresses and 32-bit accesses only
package sba_pkg;

  //////////////////////////////
  // DMI side
  //////////////////////////////

  typedef enum logic [1:0] {
    DmiNop   = 2'd0,
    DmiRead  = 2'd1,
    DmiWrite = 2'd2
  } dmi_op_e;

  // Only the system bus registers are implemented
  typedef enum logic [6:0] {
    Sbcs       = 7'h38,
    SbAddress0 = 7'h39,
    SbData0    = 7'h3C
  } dmi_addr_e;

  typedef struct packed {
    logic        valid;
    dmi_op_e     op;
    dmi_addr_e   addr;
    logic [31:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } dmi_rsp_t;

  //////////////////////////////
  // SBCS layout
  //////////////////////////////

  // Bit positions follow the debug spec; sbreadonaddr and wide accesses are absent
  typedef struct packed {
    logic [2:0] sbversion;
    logic [5:0] zero3;
    logic       sbbusyerror;
    logic       sbbusy;
    logic       zero2;
    logic [2:0] sbaccess;
    logic       sbautoincrement;
    logic       sbreadondata;
    logic [2:0] sberror;
    logic [6:0] sbasize;
    logic [1:0] zero1;
    logic       sbaccess32;
    logic [1:0] zero0;
  } sbcs_t;

  typedef union packed {
    logic [31:0] raw;
    sbcs_t       sbcs;
  } sba_word_u;

  localparam logic [2:0] SbVersion  = 3'd1;
  localparam logic [6:0] SbAsize    = 7'd32;
  localparam logic [2:0] SbAccess32 = 3'd2;

  // sberror codes
  localparam logic [2:0] SbErrNone = 3'd0;
  localparam logic [2:0] SbErrAddr = 3'd2;
  localparam logic [2:0] SbErrSize = 3'd4;

  //////////////////////////////
  // Internal paths
  //////////////////////////////

  typedef enum logic [1:0] {
    RegSbcs,
    RegAddress,
    RegData,
    RegNone
  } sba_reg_e;

  typedef struct packed {
    logic      valid;
    logic      write;
    sba_reg_e  reg_sel;
    sba_word_u data;
  } sba_cmd_t;

  typedef struct packed {
    sbcs_t       sbcs;
    logic [31:0] address;
    logic [31:0] data;
    logic        busy;
  } sba_regs_t;

  typedef struct packed {
    logic        valid;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } bus_rsp_t;

endpackage

// ==== dmi_decode.sv ====
// One command per strobe, no stall; ops other than read and write decode as no register
`timescale 1ns/1ps

module dmi_decode
  import sba_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  dmi_req_t dmi_req_i,
  output sba_cmd_t cmd_o
);

  sba_word_u wr_word;
  sba_cmd_t  cmd_d;

  logic      cmd_valid_q;
  logic      cmd_write_q;
  sba_reg_e  cmd_reg_q;
  sba_word_u cmd_data_q;

  always_comb begin
    wr_word.raw   = dmi_req_i.data;
    cmd_d         = '0;
    cmd_d.valid   = dmi_req_i.valid;
    cmd_d.write   = (dmi_req_i.op == DmiWrite);
    cmd_d.reg_sel = RegNone;
    cmd_d.data    = wr_word;

    // Register class, only for real reads and writes
    if (dmi_req_i.op == DmiRead || dmi_req_i.op == DmiWrite) begin
      case (dmi_req_i.addr)
        Sbcs:       cmd_d.reg_sel = RegSbcs;
        SbAddress0: cmd_d.reg_sel = RegAddress;
        SbData0:    cmd_d.reg_sel = RegData;
        default:    cmd_d.reg_sel = RegNone;
      endcase
    end

    // Keep only the writable SBCS fields
    if (cmd_d.reg_sel == RegSbcs) begin
      cmd_d.data.sbcs                 = '0;
      cmd_d.data.sbcs.sbbusyerror     = wr_word.sbcs.sbbusyerror;
      cmd_d.data.sbcs.sbaccess        = wr_word.sbcs.sbaccess;
      cmd_d.data.sbcs.sbautoincrement = wr_word.sbcs.sbautoincrement;
      cmd_d.data.sbcs.sbreadondata    = wr_word.sbcs.sbreadondata;
      cmd_d.data.sbcs.sberror         = wr_word.sbcs.sberror;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cmd_valid_q <= 1'b0;
    end else begin
      cmd_valid_q <= cmd_d.valid;
    end
  end

  // Payload follows the strobe
  always_ff @(posedge clk) begin
    if (dmi_req_i.valid) begin
      cmd_write_q <= cmd_d.write;
      cmd_reg_q   <= cmd_d.reg_sel;
      cmd_data_q  <= cmd_d.data;
    end
  end

  assign cmd_o = '{
    valid:   cmd_valid_q,
    write:   cmd_write_q,
    reg_sel: cmd_reg_q,
    data:    cmd_data_q
  };

endmodule

// ==== sba_execute.sv ====
// One bus access in flight at most; only word accesses, address checked against 4*MemWords
`timescale 1ns/1ps

module sba_execute
  import sba_pkg::*;
#(
  parameter int unsigned MemWords = 256
) (
  input  logic      clk,
  input  logic      rst_n_i,
  input  sba_cmd_t  cmd_i,
  input  bus_rsp_t  bus_rsp_i,
  output sba_regs_t regs_o,
  output bus_req_t  bus_req_o
);

  localparam longint unsigned AddrLimit = 64'(MemWords) * 64'd4;

  logic        busy_q, busy_d;
  logic        busyerr_q, busyerr_d;
  logic        readondata_q, readondata_d;
  logic [2:0]  access_q, access_d;
  logic        autoinc_q, autoinc_d;
  logic [2:0]  sberror_q, sberror_d;
  logic [31:0] address_q, address_d;
  logic [31:0] data_q, data_d;

  logic        trigger;
  logic        start;
  logic        bus_valid_q;
  logic        bus_we_q;
  logic [31:0] bus_addr_q;
  logic [31:0] bus_wdata_q;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    busy_d       = busy_q;
    busyerr_d    = busyerr_q;
    readondata_d = readondata_q;
    access_d     = access_q;
    autoinc_d    = autoinc_q;
    sberror_d    = sberror_q;
    address_d    = address_q;
    data_d       = data_q;
    trigger      = 1'b0;
    start        = 1'b0;

    // Bus completion
    if (bus_rsp_i.valid) begin
      busy_d = 1'b0;
      if (!bus_we_q) begin
        data_d = bus_rsp_i.rdata;
      end
      if (autoinc_q) begin
        address_d = address_q + 32'd4;
      end
    end

    if (cmd_i.valid) begin
      case (cmd_i.reg_sel)
        RegSbcs: begin
          if (cmd_i.write) begin
            // Error bits are write-one-to-clear
            busyerr_d    = busyerr_q & ~cmd_i.data.sbcs.sbbusyerror;
            sberror_d    = sberror_q & ~cmd_i.data.sbcs.sberror;
            readondata_d = cmd_i.data.sbcs.sbreadondata;
            access_d     = cmd_i.data.sbcs.sbaccess;
            autoinc_d    = cmd_i.data.sbcs.sbautoincrement;
          end
        end
        RegAddress: begin
          if (busy_q) begin
            busyerr_d = 1'b1;
          end else if (cmd_i.write) begin
            address_d = cmd_i.data.raw;
          end
        end
        RegData: begin
          if (busy_q) begin
            busyerr_d = 1'b1;
          end else begin
            if (cmd_i.write) begin
              data_d = cmd_i.data.raw;
            end
            trigger = cmd_i.write | readondata_q;
          end
        end
        default: ;
      endcase
    end

    // Pending errors block new accesses
    if (trigger && sberror_q == SbErrNone && !busyerr_q) begin
      if (access_q != SbAccess32) begin
        sberror_d = SbErrSize;
      end else if (64'(address_q) >= AddrLimit) begin
        sberror_d = SbErrAddr;
      end else begin
        start  = 1'b1;
        busy_d = 1'b1;
      end
    end
  end

  //////////////////////////////
  // State registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q       <= 1'b0;
      busyerr_q    <= 1'b0;
      readondata_q <= 1'b0;
      access_q     <= SbAccess32;
      autoinc_q    <= 1'b0;
      sberror_q    <= SbErrNone;
      address_q    <= '0;
      data_q       <= '0;
      bus_valid_q  <= 1'b0;
    end else begin
      busy_q       <= busy_d;
      busyerr_q    <= busyerr_d;
      readondata_q <= readondata_d;
      access_q     <= access_d;
      autoinc_q    <= autoinc_d;
      sberror_q    <= sberror_d;
      address_q    <= address_d;
      data_q       <= data_d;
      bus_valid_q  <= start;
    end
  end

  // Request payload, captured at the trigger edge
  always_ff @(posedge clk) begin
    if (start) begin
      bus_we_q    <= cmd_i.write;
      bus_addr_q  <= address_q;
      bus_wdata_q <= cmd_i.data.raw;
    end
  end

  assign bus_req_o = '{valid: bus_valid_q, we: bus_we_q, addr: bus_addr_q, wdata: bus_wdata_q};

  // Live fields only, fixed fields and sbbusy are merged on readout
  always_comb begin
    regs_o                      = '0;
    regs_o.sbcs.sbbusyerror     = busyerr_q;
    regs_o.sbcs.sbreadondata    = readondata_q;
    regs_o.sbcs.sbaccess        = access_q;
    regs_o.sbcs.sbautoincrement = autoinc_q;
    regs_o.sbcs.sberror         = sberror_q;
    regs_o.address              = address_q;
    regs_o.data                 = data_q;
    regs_o.busy                 = busy_q;
  end

endmodule

// ==== sba_result.sv ====
// Response two cycles after the strobe; reads see register state before their own effects
`timescale 1ns/1ps

module sba_result
  import sba_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  sba_cmd_t  cmd_i,
  input  sba_regs_t regs_i,
  output dmi_rsp_t  dmi_rsp_o
);

  sba_word_u   sbcs_view;
  logic [31:0] rdata;
  logic        rsp_valid_q;
  logic [31:0] rsp_data_q;

  always_comb begin
    // Constant fields plus the busy flag on top of the live ones
    sbcs_view.sbcs            = regs_i.sbcs;
    sbcs_view.sbcs.sbversion  = SbVersion;
    sbcs_view.sbcs.sbasize    = SbAsize;
    sbcs_view.sbcs.sbaccess32 = 1'b1;
    sbcs_view.sbcs.sbbusy     = regs_i.busy;

    rdata = '0;
    if (!cmd_i.write) begin
      case (cmd_i.reg_sel)
        RegSbcs:    rdata = sbcs_view.raw;
        RegAddress: rdata = regs_i.address;
        RegData:    rdata = regs_i.data;
        default:    rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= cmd_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_i.valid) begin
      rsp_data_q <= rdata;
    end
  end

  assign dmi_rsp_o = '{valid: rsp_valid_q, data: rsp_data_q};

endmodule

// ==== sys_mem.sv ====
// Word memory, contents undefined after power-up; byte address bits [1:0] are ignored
`timescale 1ns/1ps

module sys_mem
  import sba_pkg::*;
#(
  parameter int unsigned MemWords = 256
) (
  input  logic     clk,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o
);

  localparam int unsigned IdxWidth = $clog2(MemWords);

  logic [31:0]         mem_q [MemWords];
  logic [IdxWidth-1:0] idx;
  logic                rsp_valid_q;
  logic [31:0]         rsp_rdata_q;

  // Word index from the byte address
  assign idx = bus_req_i.addr[IdxWidth+1:2];

  always_ff @(posedge clk) begin
    if (bus_req_i.valid && bus_req_i.we) begin
      mem_q[idx] <= bus_req_i.wdata;
    end
  end

  // Response one cycle after every request
  always_ff @(posedge clk) begin
    rsp_valid_q <= bus_req_i.valid;
    if (bus_req_i.valid && !bus_req_i.we) begin
      rsp_rdata_q <= mem_q[idx];
    end
  end

  assign bus_rsp_o = '{valid: rsp_valid_q, rdata: rsp_rdata_q};

endmodule

// ==== dbg_sba_top.sv ====
// DMI driven directly with plain strobes; response two cycles after each request, no stall
`timescale 1ns/1ps

module dbg_sba_top
  import sba_pkg::*;
#(
  parameter int unsigned MemWords = 256
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  dmi_req_t dmi_req_i,
  output dmi_rsp_t dmi_rsp_o
);

  sba_cmd_t  cmd;
  sba_regs_t regs;
  bus_req_t  bus_req;
  bus_rsp_t  bus_rsp;

  dmi_decode i_dmi_decode (
    .clk       ( clk       ),
    .rst_n_i   ( rst_n_i   ),
    .dmi_req_i ( dmi_req_i ),
    .cmd_o     ( cmd       )
  );

  sba_execute #(
    .MemWords ( MemWords )
  ) i_sba_execute (
    .clk       ( clk     ),
    .rst_n_i   ( rst_n_i ),
    .cmd_i     ( cmd     ),
    .bus_rsp_i ( bus_rsp ),
    .regs_o    ( regs    ),
    .bus_req_o ( bus_req )
  );

  sba_result i_sba_result (
    .clk       ( clk       ),
    .rst_n_i   ( rst_n_i   ),
    .cmd_i     ( cmd       ),
    .regs_i    ( regs      ),
    .dmi_rsp_o ( dmi_rsp_o )
  );

  sys_mem #(
    .MemWords ( MemWords )
  ) i_sys_mem (
    .clk       ( clk     ),
    .bus_req_i ( bus_req ),
    .bus_rsp_o ( bus_rsp )
  );

endmodule

// ==== tb_dbg_sba.sv ====
// Host drives one DMI request at a time except in the busy error test; memory depth fixed at 256
`timescale 1ns/1ps

module tb_dbg_sba
  import sba_pkg::*;
();

  localparam int unsigned MemWords    = 256;
  localparam int unsigned RspTimeout  = 20;
  localparam int unsigned BusyTimeout = 50;

  logic        clk;
  logic        rst_n_i;
  dmi_req_t    dmi_req;
  dmi_rsp_t    dmi_rsp;
  logic        req_valid;
  logic        rsp_valid;
  int          mismatch_cnt;
  int          assert_cnt;
  int          timeout_cnt;
  logic [31:0] ref_mem [MemWords];

  dbg_sba_top #(
    .MemWords ( MemWords )
  ) i_dut (
    .clk       ( clk     ),
    .rst_n_i   ( rst_n_i ),
    .dmi_req_i ( dmi_req ),
    .dmi_rsp_o ( dmi_rsp )
  );

  always #50 clk = ~clk;

  assign req_valid = dmi_req.valid;
  assign rsp_valid = dmi_rsp.valid;

  // Exactly one response pulse per strobe, two cycles later
  rsp_follows_req: assert property (
    @(posedge clk) disable iff (!rst_n_i) rsp_valid == $past(req_valid, 2)
  ) else begin
    assert_cnt++;
    $display("Response pulse at %0t does not line up with a request strobe", $time);
  end

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      mismatch_cnt++;
      $display("Mismatch %s: expected %08h actual %08h", name, exp, act);
    end
  endtask

  // Advances at least one cycle, so a pulse is never consumed twice
  task automatic wait_rsp(output logic [31:0] data);
    int unsigned cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      #10;
      cycles++;
    end while (!dmi_rsp.valid && cycles < RspTimeout);
    if (!dmi_rsp.valid) begin
      timeout_cnt++;
      $display("No DMI response within %0d cycles at %0t", RspTimeout, $time);
    end
    data = dmi_rsp.data;
  endtask

  task automatic dmi_read(input dmi_addr_e addr, output logic [31:0] data);
    dmi_req = '{valid: 1'b1, op: DmiRead, addr: addr, data: 32'h0};
    @(posedge clk);
    #10;
    dmi_req = '0;
    wait_rsp(data);
  endtask

  task automatic dmi_write(input dmi_addr_e addr, input logic [31:0] data);
    logic [31:0] rsp_data;
    dmi_req = '{valid: 1'b1, op: DmiWrite, addr: addr, data: data};
    @(posedge clk);
    #10;
    dmi_req = '0;
    wait_rsp(rsp_data);
    check_word("write response data", 32'h0, rsp_data);
  endtask

  task automatic poll_busy();
    sba_word_u   status;
    logic [31:0] word;
    int unsigned polls;
    polls = 0;
    do begin
      dmi_read(Sbcs, word);
      status.raw = word;
      polls++;
    end while (status.sbcs.sbbusy && polls < BusyTimeout);
    if (status.sbcs.sbbusy) begin
      timeout_cnt++;
      $display("sbbusy still set after %0d polls at %0t", BusyTimeout, $time);
    end
  endtask

  task automatic write_sbcs(input logic rod, input logic autoinc, input logic [2:0] access,
                            input logic clr_busyerr, input logic [2:0] clr_err);
    sba_word_u w;
    w.raw                  = '0;
    w.sbcs.sbreadondata    = rod;
    w.sbcs.sbautoincrement = autoinc;
    w.sbcs.sbaccess        = access;
    w.sbcs.sbbusyerror     = clr_busyerr;
    w.sbcs.sberror         = clr_err;
    dmi_write(Sbcs, w.raw);
  endtask

  task automatic check_errors(input string name, input logic busyerr, input logic [2:0] err);
    sba_word_u   status;
    logic [31:0] word;
    dmi_read(Sbcs, word);
    status.raw = word;
    check_word({name, " sbbusyerror"}, 32'(busyerr), 32'(status.sbcs.sbbusyerror));
    check_word({name, " sberror"}, 32'(err), 32'(status.sbcs.sberror));
  endtask

  // Dummy read primes the data register and the second read returns the word
  task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
    logic [31:0] dummy;
    write_sbcs(1'b1, 1'b0, 3'd2, 1'b0, 3'd0);
    dmi_write(SbAddress0, addr);
    dmi_read(SbData0, dummy);
    poll_busy();
    dmi_read(SbData0, data);
    poll_busy();
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] first_w;
    logic [31:0] second_w;
    sba_word_u   exp_sbcs;
    clk          = 1'b0;
    rst_n_i      = 1'b0;
    dmi_req      = '0;
    mismatch_cnt = 0;
    assert_cnt   = 0;
    timeout_cnt  = 0;
    void'($urandom(32'h6513_d0d6));

    repeat (16) begin
      @(posedge clk);
      #10;
      check_word("response valid in reset", 32'h0, 32'(dmi_rsp.valid));
    end
    rst_n_i = 1'b1;
    @(posedge clk);
    #10;
    check_word("response valid after reset", 32'h0, 32'(dmi_rsp.valid));

    //////////////////////////////
    // SBCS after reset
    //////////////////////////////
    exp_sbcs.raw             = '0;
    exp_sbcs.sbcs.sbversion  = 3'd1;
    exp_sbcs.sbcs.sbasize    = 7'd32;
    exp_sbcs.sbcs.sbaccess32 = 1'b1;
    exp_sbcs.sbcs.sbaccess   = 3'd2;
    dmi_read(Sbcs, rd);
    check_word("sbcs reset value", exp_sbcs.raw, rd);

    //////////////////////////////
    // Preload and readback
    //////////////////////////////
    write_sbcs(1'b0, 1'b1, 3'd2, 1'b0, 3'd0);
    dmi_write(SbAddress0, 32'h40);
    for (int i = 0; i < 32; i++) begin
      ref_mem[16 + i] = $urandom;
      dmi_write(SbData0, ref_mem[16 + i]);
      poll_busy();
    end
    write_sbcs(1'b1, 1'b1, 3'd2, 1'b0, 3'd0);
    dmi_write(SbAddress0, 32'h40);
    dmi_read(SbData0, rd);
    poll_busy();
    for (int i = 0; i < 32; i++) begin
      dmi_read(SbData0, rd);
      check_word($sformatf("preload word %0d", i), ref_mem[16 + i], rd);
      poll_busy();
    end
    // Dummy read plus 32 reads each step the address by 4
    dmi_read(SbAddress0, rd);
    check_word("auto-increment address", 32'h40 + 32'd4 * 32'd33, rd);

    //////////////////////////////
    // Busy error
    //////////////////////////////
    write_sbcs(1'b0, 1'b0, 3'd2, 1'b0, 3'd0);
    dmi_write(SbAddress0, 32'h200);
    first_w  = $urandom;
    second_w = ~first_w;
    dmi_req = '{valid: 1'b1, op: DmiWrite, addr: SbData0, data: first_w};
    @(posedge clk);
    #10;
    dmi_req.data = second_w;
    @(posedge clk);
    #10;
    dmi_req = '0;
    // First pulse is up right now, the wait picks up the second one
    wait_rsp(rd);
    poll_busy();
    check_errors("busy error set", 1'b1, 3'd0);
    write_sbcs(1'b0, 1'b0, 3'd2, 1'b1, 3'd0);
    check_errors("busy error cleared", 1'b0, 3'd0);
    ref_mem[128] = first_w;
    read_word(32'h200, rd);
    check_word("busy error memory", ref_mem[128], rd);

    //////////////////////////////
    // Size and address errors
    //////////////////////////////
    write_sbcs(1'b0, 1'b0, 3'd2, 1'b0, 3'd0);
    dmi_write(SbAddress0, 32'h300);
    ref_mem[192] = $urandom;
    dmi_write(SbData0, ref_mem[192]);
    poll_busy();
    write_sbcs(1'b0, 1'b0, 3'd3, 1'b0, 3'd0);
    dmi_write(SbData0, ~ref_mem[192]);
    check_errors("size error", 1'b0, 3'd4);
    write_sbcs(1'b0, 1'b0, 3'd2, 1'b0, 3'd0);
    dmi_write(SbData0, ~ref_mem[192]);
    check_errors("size error pending", 1'b0, 3'd4);
    write_sbcs(1'b0, 1'b0, 3'd2, 1'b0, 3'd7);
    check_errors("size error cleared", 1'b0, 3'd0);
    dmi_write(SbAddress0, 32'd1024);
    dmi_write(SbData0, ~ref_mem[192]);
    check_errors("address error", 1'b0, 3'd2);
    dmi_write(SbAddress0, 32'h300);
    dmi_write(SbData0, ~ref_mem[192]);
    check_errors("address error pending", 1'b0, 3'd2);
    write_sbcs(1'b0, 1'b0, 3'd2, 1'b0, 3'd7);
    check_errors("address error cleared", 1'b0, 3'd0);
    read_word(32'h300, rd);
    check_word("memory after errors", ref_mem[192], rd);
    ref_mem[192] = $urandom;
    dmi_write(SbData0, ref_mem[192]);
    poll_busy();
    read_word(32'h300, rd);
    check_word("access after clearing", ref_mem[192], rd);

    $display("Error counts: %0d mismatches, %0d assertion failures, %0d timeouts",
             mismatch_cnt, assert_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && assert_cnt == 0 && timeout_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
sba_pkg.sv
dmi_decode.sv
sba_execute.sv
sba_result.sv
sys_mem.sv
dbg_sba_top.sv
tb_dbg_sba.sv
